// File: source/frame_pkg.sv
package frame_pkg;

  typedef logic [7:0] byte_t;

  // FIFO geometry
  localparam int ADDR_W     = 4;
  localparam int FIFO_DEPTH = 2 ** ADDR_W;

  typedef logic [ADDR_W:0] ptr_t;  // Top bit marks the wrap

  typedef struct packed {
    byte_t data;
    logic  last;
    logic  bad;  // User flag on the last beat
  } stream_beat_t;

  typedef logic [1:0]  reg_addr_t;
  typedef logic [15:0] reg_data_t;

  localparam reg_addr_t REG_CTRL = 2'd0;
  localparam reg_addr_t REG_GOOD = 2'd1;
  localparam reg_addr_t REG_BAD  = 2'd2;
  localparam reg_addr_t REG_OVFL = 2'd3;

  // Bit positions in REG_CTRL
  localparam int CTRL_DROP_BAD  = 0;
  localparam int CTRL_DROP_FULL = 1;

  typedef struct packed {
    reg_addr_t addr;
    reg_data_t wdata;
    logic      we;
  } reg_req_t;

  // One-cycle pulses, at most one per frame end
  typedef struct packed {
    logic good;
    logic bad;
    logic overflow;
  } frame_status_t;

endpackage

// File: source/frame_fifo.sv
module frame_fifo
  import frame_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  stream_beat_t  s_beat,
  input  logic          s_valid,
  output logic          s_ready,
  output stream_beat_t  m_beat,
  output logic          m_valid,
  input  logic          m_ready,
  input  logic          drop_bad,
  input  logic          drop_full,
  output frame_status_t status
);

  stream_beat_t mem [FIFO_DEPTH];

  ptr_t spec_ptr;    // Next slot of the frame being written
  ptr_t commit_ptr;  // End of the last good frame
  ptr_t vis_ptr;     // Commit point as seen by the read side
  ptr_t rd_ptr;
  ptr_t spec_next;
  ptr_t commit_next;

  logic          drop_frame;  // Rest of current frame is discarded
  logic          drop_next;
  frame_status_t status_next;

  logic              wr_en;
  logic              wr_en_q;
  logic [ADDR_W-1:0] wr_addr_q;
  stream_beat_t      wr_data_q;

  logic         full_cur;
  logic         full_wr;
  logic         empty;
  logic         read;
  logic         store_out;
  stream_beat_t rd_data;
  logic         rd_valid;

  // No room beside the committed frames
  assign full_cur = ptr_t'(spec_ptr - rd_ptr) == ptr_t'(FIFO_DEPTH);
  // Current frame alone fills the FIFO
  assign full_wr  = ptr_t'(spec_ptr - commit_ptr) == ptr_t'(FIFO_DEPTH);

  assign s_ready = !full_cur || full_wr || drop_full;

  always_comb begin
    wr_en       = 1'b0;
    spec_next   = spec_ptr;
    commit_next = commit_ptr;
    drop_next   = drop_frame;
    status_next = '0;
    if (s_valid && s_ready) begin
      if (full_cur || full_wr || drop_frame) begin
        drop_next = 1'b1;
        if (s_beat.last) begin
          spec_next            = commit_ptr;  // Rewind
          drop_next            = 1'b0;
          status_next.overflow = 1'b1;
        end
      end else begin
        wr_en     = 1'b1;
        spec_next = spec_ptr + 1'b1;
        if (s_beat.last) begin
          if (s_beat.bad && drop_bad) begin
            spec_next       = commit_ptr;
            status_next.bad = 1'b1;
          end else begin
            commit_next      = spec_ptr + 1'b1;
            status_next.good = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      spec_ptr   <= '0;
      commit_ptr <= '0;
      vis_ptr    <= '0;
      drop_frame <= 1'b0;
      status     <= '0;
      wr_en_q    <= 1'b0;
    end else begin
      spec_ptr   <= spec_next;
      commit_ptr <= commit_next;
      vis_ptr    <= commit_ptr;  // Follows the delayed memory write
      drop_frame <= drop_next;
      status     <= status_next;
      wr_en_q    <= wr_en;
    end
  end

  // Memory is written one cycle after the transfer
  always_ff @(posedge clk) begin
    wr_addr_q <= spec_ptr[ADDR_W-1:0];
    wr_data_q <= s_beat;
    if (wr_en_q) begin
      mem[wr_addr_q] <= wr_data_q;
    end
  end

  assign empty     = vis_ptr == rd_ptr;
  assign store_out = m_ready || !m_valid;
  assign read      = !empty && (store_out || !rd_valid);

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr   <= '0;
      rd_valid <= 1'b0;
      m_valid  <= 1'b0;
    end else begin
      if (read) begin
        rd_ptr   <= rd_ptr + 1'b1;
        rd_valid <= 1'b1;
      end else if (store_out) begin
        rd_valid <= 1'b0;  // Nothing behind the output beat
      end
      if (store_out) begin
        m_valid <= rd_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      rd_data <= mem[rd_ptr[ADDR_W-1:0]];
    end
    if (store_out) begin
      m_beat <= rd_data;
    end
  end

  a_out_stable: assert property (@(posedge clk) disable iff (rst)
    m_valid && !m_ready |=> m_valid && $stable(m_beat))
    else $error("m_beat changed while stalled");

  a_status_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(status))
    else $error("more than one status pulse");

  // Read side only trails the committed data
  a_commit_span: assert property (@(posedge clk) disable iff (rst)
    ptr_t'(commit_ptr - rd_ptr) <= ptr_t'(FIFO_DEPTH))
    else $error("committed pointer ahead of read pointer by more than depth");

endmodule

// File: source/frame_regs.sv
module frame_regs
  import frame_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  reg_req_t      reg_req,
  input  logic          reg_req_valid,
  output logic          reg_ack,
  output reg_data_t     reg_rdata,
  input  frame_status_t status,
  output logic          drop_bad,
  output logic          drop_full
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACK,
    ST_WAIT
  } reg_state_t;

  reg_state_t state;
  reg_state_t state_next;

  reg_data_t  cnt [1:3];  // Indexed by register address
  logic [3:1] inc;
  logic       access;
  reg_data_t  rd_mux;

  assign inc     = {status.overflow, status.bad, status.good};
  assign access  = (state == ST_IDLE) && reg_req_valid;
  assign reg_ack = state != ST_IDLE;

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: if (reg_req_valid) state_next = ST_ACK;
      ST_ACK:  state_next = reg_req_valid ? ST_WAIT : ST_IDLE;
      ST_WAIT: if (!reg_req_valid) state_next = ST_IDLE;  // Released
      default: state_next = ST_IDLE;
    endcase
  end

  always_comb begin
    rd_mux = '0;
    if (reg_req.addr == REG_CTRL) begin
      rd_mux[CTRL_DROP_BAD]  = drop_bad;
      rd_mux[CTRL_DROP_FULL] = drop_full;
    end else begin
      rd_mux = cnt[reg_req.addr];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_IDLE;
      drop_bad  <= 1'b0;
      drop_full <= 1'b0;
      for (int i = 1; i <= 3; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      state <= state_next;
      if (access && reg_req.we && reg_req.addr == REG_CTRL) begin
        drop_bad  <= reg_req.wdata[CTRL_DROP_BAD];
        drop_full <= reg_req.wdata[CTRL_DROP_FULL];
      end
      for (int i = 1; i <= 3; i++) begin
        if (access && reg_req.we && reg_req.addr == reg_addr_t'(i)) begin
          cnt[i] <= '0;  // Clear beats a same-cycle increment
        end else if (inc[i]) begin
          cnt[i] <= cnt[i] + 1'b1;
        end
      end
    end
  end

  // Sampled before the write lands
  always_ff @(posedge clk) begin
    if (access) begin
      reg_rdata <= rd_mux;
    end
  end

  a_ack_after_req: assert property (@(posedge clk) disable iff (rst)
    $rose(reg_ack) |-> $past(reg_req_valid))
    else $error("ack raised without a request");

endmodule

// File: source/frame_buffer_top.sv
module frame_buffer_top
  import frame_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  stream_beat_t s_beat,
  input  logic         s_valid,
  output logic         s_ready,
  output stream_beat_t m_beat,
  output logic         m_valid,
  input  logic         m_ready,
  input  reg_req_t     reg_req,
  input  logic         reg_req_valid,
  output logic         reg_ack,
  output reg_data_t    reg_rdata
);

  logic          drop_bad;
  logic          drop_full;
  frame_status_t status;

  frame_fifo frame_fifo_i (
    .clk       (clk),
    .rst       (rst),
    .s_beat    (s_beat),
    .s_valid   (s_valid),
    .s_ready   (s_ready),
    .m_beat    (m_beat),
    .m_valid   (m_valid),
    .m_ready   (m_ready),
    .drop_bad  (drop_bad),
    .drop_full (drop_full),
    .status    (status)
  );

  frame_regs frame_regs_i (
    .clk           (clk),
    .rst           (rst),
    .reg_req       (reg_req),
    .reg_req_valid (reg_req_valid),
    .reg_ack       (reg_ack),
    .reg_rdata     (reg_rdata),
    .status        (status),
    .drop_bad      (drop_bad),
    .drop_full     (drop_full)
  );

endmodule

// File: tb/frame_buffer_checker.sv
module frame_buffer_checker
  import frame_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  stream_beat_t s_beat,
  input  logic         s_valid,
  input  logic         s_ready,
  input  stream_beat_t m_beat,
  input  logic         m_valid,
  input  logic         m_ready,
  input  reg_req_t     reg_req,
  input  logic         reg_req_valid,
  input  logic         reg_ack,
  input  reg_data_t    reg_rdata,
  input  int           phase,
  input  logic         run_done,
  output int           errors,
  output logic         report_ready
);

  timeunit 1ns;
  timeprecision 1ps;

  stream_beat_t expected [$];  // Beats of kept frames, in order
  stream_beat_t frame [$];     // Frame still arriving
  stream_beat_t exp_beat;
  logic         drop_bad_m;
  logic         drop_full_m;
  reg_data_t    good_cnt;
  reg_data_t    bad_cnt;
  reg_data_t    ovfl_cnt;
  reg_data_t    read_exp;
  reg_addr_t    read_addr;
  logic         read_pending;
  logic         req_q;
  logic         ack_q;
  logic         check_idle;
  int           beats_checked;
  int           reads_checked;

  function automatic string test_name(input int p);
    case (p)
      1: return "good_frames";
      2: return "drop_bad";
      3: return "overflow_stall";
      4: return "overflow_drop";
      default: return "counters";
    endcase
  endfunction

  function automatic reg_data_t model_value(input reg_addr_t addr);
    reg_data_t v;
    v = '0;
    case (addr)
      REG_CTRL: begin
        v[CTRL_DROP_BAD]  = drop_bad_m;
        v[CTRL_DROP_FULL] = drop_full_m;
      end
      REG_GOOD: v = good_cnt;
      REG_BAD:  v = bad_cnt;
      REG_OVFL: v = ovfl_cnt;
    endcase
    return v;
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      expected.delete();
      frame.delete();
      drop_bad_m    = 1'b0;
      drop_full_m   = 1'b0;
      good_cnt      = '0;
      bad_cnt       = '0;
      ovfl_cnt      = '0;
      read_pending  = 1'b0;
      req_q         = 1'b0;
      ack_q         = 1'b0;
      check_idle    = 1'b1;
      beats_checked = 0;
      reads_checked = 0;
      errors        = 0;
      report_ready  = 1'b0;
    end else begin
      if (check_idle && (m_valid || reg_ack || !s_ready)) begin
        errors++;
        $display("outputs not idle after reset: m_valid %b reg_ack %b s_ready %b",
                 m_valid, reg_ack, s_ready);
      end
      check_idle = 1'b0;

      if (s_valid && s_ready) begin
        frame.push_back(s_beat);
        if (s_beat.last) begin
          if (frame.size() > FIFO_DEPTH) begin
            ovfl_cnt++;
          end else if (s_beat.bad && drop_bad_m) begin
            bad_cnt++;
          end else begin
            good_cnt++;
            foreach (frame[i]) expected.push_back(frame[i]);
          end
          frame.delete();
        end
      end
      if (drop_full_m && !s_ready) begin
        errors++;
        $display("s_ready fell while oversize frames are being dropped");
      end

      if (m_valid && m_ready) begin
        if (expected.size() == 0) begin
          errors++;
          $display("output beat %h appeared with no frame pending", m_beat);
        end else begin
          exp_beat = expected.pop_front();
          if (m_beat !== exp_beat) begin
            errors++;
            $display("FAIL %s: beat %0d expected %h actual %h",
                     test_name(phase), beats_checked, exp_beat, m_beat);
          end
          beats_checked++;
        end
      end

      // Four-phase rules on values seen one edge apart
      if (reg_ack && !ack_q && !req_q) begin
        errors++;
        $display("reg_ack rose without a request");
      end
      if (req_q && !ack_q && !reg_ack) begin
        errors++;
        $display("reg_ack did not rise one cycle after the request");
      end
      if (!reg_ack && ack_q && req_q) begin
        errors++;
        $display("reg_ack fell while the request was still high");
      end
      if (reg_ack && ack_q && !req_q) begin
        errors++;
        $display("reg_ack stayed high after the request fell");
      end

      if (reg_ack && !ack_q && read_pending) begin
        if (reg_rdata !== read_exp) begin
          errors++;
          $display("FAIL %s: register %0d expected %h actual %h",
                   test_name(phase), read_addr, read_exp, reg_rdata);
        end
        read_pending = 1'b0;
        reads_checked++;
      end

      if (reg_req_valid && !reg_ack) begin
        if (reg_req.we) begin
          case (reg_req.addr)
            REG_CTRL: begin
              drop_bad_m  = reg_req.wdata[CTRL_DROP_BAD];
              drop_full_m = reg_req.wdata[CTRL_DROP_FULL];
            end
            REG_GOOD: good_cnt = '0;
            REG_BAD:  bad_cnt  = '0;
            REG_OVFL: ovfl_cnt = '0;
          endcase
        end else begin
          read_pending = 1'b1;
          read_addr    = reg_req.addr;
          read_exp     = model_value(reg_req.addr);  // Value before the access
        end
      end
      req_q = reg_req_valid;
      ack_q = reg_ack;

      if (run_done && !report_ready) begin
        if (expected.size() != 0) begin
          errors++;
          $display("%0d expected beats never came out", expected.size());
        end
        $display("checker: %0d errors, %0d beats and %0d register reads checked",
                 errors, beats_checked, reads_checked);
        report_ready = 1'b1;
      end
    end
  end

endmodule

// File: tb/frame_buffer_tb.sv
module frame_buffer_tb
  import frame_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  logic         clk;
  logic         rst;
  stream_beat_t s_beat;
  logic         s_valid;
  logic         s_ready;
  stream_beat_t m_beat;
  logic         m_valid;
  logic         m_ready;
  reg_req_t     reg_req;
  logic         reg_req_valid;
  logic         reg_ack;
  reg_data_t    reg_rdata;

  int   phase;
  logic run_done;
  logic report_ready;
  int   errors;
  int   beats_sent;
  int   cycles;
  int   stall_left;  // Cycles of forced back-pressure

  frame_buffer_top frame_buffer_top_i (
    .clk           (clk),
    .rst           (rst),
    .s_beat        (s_beat),
    .s_valid       (s_valid),
    .s_ready       (s_ready),
    .m_beat        (m_beat),
    .m_valid       (m_valid),
    .m_ready       (m_ready),
    .reg_req       (reg_req),
    .reg_req_valid (reg_req_valid),
    .reg_ack       (reg_ack),
    .reg_rdata     (reg_rdata)
  );

  frame_buffer_checker checker_i (
    .clk           (clk),
    .rst           (rst),
    .s_beat        (s_beat),
    .s_valid       (s_valid),
    .s_ready       (s_ready),
    .m_beat        (m_beat),
    .m_valid       (m_valid),
    .m_ready       (m_ready),
    .reg_req       (reg_req),
    .reg_req_valid (reg_req_valid),
    .reg_ack       (reg_ack),
    .reg_rdata     (reg_rdata),
    .phase         (phase),
    .run_done      (run_done),
    .errors        (errors),
    .report_ready  (report_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    m_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (stall_left > 0) begin
        m_ready = 1'b0;
        stall_left--;
      end else begin
        m_ready = $urandom_range(2) != 0;
      end
    end
  end

  // Limit grows with the stimulus
  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > beats_sent * 4 + 2000) begin
        $display("timeout: DUT stopped making progress after %0d cycles", cycles);
        $display("tests failed");
        $finish;
      end
    end
  end

  task automatic send_frame(input int len, input bit bad);
    stream_beat_t beat;
    for (int i = 0; i < len; i++) begin
      beat.data = byte_t'($urandom);
      beat.last = i == len - 1;
      beat.bad  = (i == len - 1) && bad;
      s_beat    = beat;
      s_valid   = 1'b1;
      beats_sent++;
      do @(posedge clk); while (!s_ready);
      #1;
    end
    s_valid = 1'b0;
  endtask

  task automatic send_random_frames(input int count, input int max_len);
    int gap;
    for (int f = 0; f < count; f++) begin
      send_frame(1 + int'($urandom_range(max_len - 1)), $urandom_range(3) == 0);
      gap = int'($urandom_range(2));
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  task automatic reg_access(input reg_addr_t addr, input logic we, input reg_data_t wdata);
    reg_req.addr  = addr;
    reg_req.wdata = wdata;
    reg_req.we    = we;
    reg_req_valid = 1'b1;
    do @(posedge clk); while (!reg_ack);
    #1;
    reg_req_valid = 1'b0;
    do @(posedge clk); while (reg_ack);
    #1;
  endtask

  task automatic read_all_registers();
    reg_access(REG_CTRL, 1'b0, '0);
    reg_access(REG_GOOD, 1'b0, '0);
    reg_access(REG_BAD, 1'b0, '0);
    reg_access(REG_OVFL, 1'b0, '0);
  endtask

  task automatic clear_counters();
    reg_access(REG_GOOD, 1'b1, reg_data_t'($urandom));
    reg_access(REG_BAD, 1'b1, reg_data_t'($urandom));
    reg_access(REG_OVFL, 1'b1, reg_data_t'($urandom));
  endtask

  // Idle once nothing has come out for a while
  task automatic wait_output_idle();
    int quiet;
    quiet = 0;
    while (quiet < 8) begin
      @(posedge clk);
      quiet = m_valid ? 0 : quiet + 1;
    end
    #1;
  endtask

  initial begin
    void'($urandom(15001));
    s_beat        = '0;
    s_valid       = 1'b0;
    reg_req       = '0;
    reg_req_valid = 1'b0;
    run_done      = 1'b0;
    beats_sent    = 0;
    stall_left    = 0;
    phase         = 1;
    rst           = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    send_random_frames(30, 12);
    wait_output_idle();
    read_all_registers();

    phase = 2;
    reg_access(REG_CTRL, 1'b1, 16'h0001);
    send_random_frames(30, 12);
    wait_output_idle();
    read_all_registers();
    reg_access(REG_CTRL, 1'b1, 16'h0000);
    send_random_frames(10, 12);
    wait_output_idle();
    read_all_registers();

    phase = 3;
    repeat (4) send_frame(17 + int'($urandom_range(7)), $urandom_range(1) == 1);
    stall_left = 60;  // Output held off while 12-beat frames pile up
    repeat (3) send_frame(12, 1'b0);
    wait_output_idle();
    read_all_registers();

    phase = 4;
    reg_access(REG_CTRL, 1'b1, 16'h0002);
    repeat (8) begin
      wait_output_idle();
      send_frame(1 + int'($urandom_range(23)), $urandom_range(1) == 1);
    end
    wait_output_idle();
    read_all_registers();
    reg_access(REG_CTRL, 1'b1, 16'h0000);
    wait_output_idle();

    phase = 5;
    clear_counters();
    read_all_registers();
    reg_access(REG_CTRL, 1'b1, 16'h0001);
    send_random_frames(12, 20);
    wait_output_idle();
    read_all_registers();
    clear_counters();
    read_all_registers();

    run_done = 1'b1;
    wait (report_ready);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: frame_buffer_top.f
source/frame_pkg.sv
source/frame_fifo.sv
source/frame_regs.sv
source/frame_buffer_top.sv
tb/frame_buffer_checker.sv
tb/frame_buffer_tb.sv

// File: Makefile
TOP = frame_buffer_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): frame_buffer_top.f source/*.sv tb/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f frame_buffer_top.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
